// File: Makefile
.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal -f verilog.f \
		--top-module camera_tracker_tb -Mdir obj_dir
	./obj_dir/Vcamera_tracker_tb | tee sim.log
	grep -q "RESULT: PASS" sim.log

clean:
	rm -rf obj_dir sim.log

// File: dv/camera_frames.svh
typedef struct packed {
    bit on;
    int x0;
    int y0;
    int x1;
    int y1;
} rect_t;

logic [31:0] lfsr_state = 32'hfd19;

function automatic rect_t make_rect(int x0, int y0, int x1, int y1);
    rect_t r;
    r.on = 1'b1;
    r.x0 = x0;
    r.y0 = y0;
    r.x1 = x1;
    r.y1 = y1;
    return r;
endfunction

// galois form, x^32 + x^22 + x^2 + x + 1
function automatic logic lfsr_bit();
    logic out;
    out = lfsr_state[0];
    lfsr_state = lfsr_state >> 1;
    if (out) lfsr_state = lfsr_state ^ 32'h8020_0003;
    return out;
endfunction

function automatic int random_bits(int n);
    int v;
    v = 0;
    for (int i = 0; i < n; i++) v = (v << 1) | int'(lfsr_bit());
    return v;
endfunction

// background colours that match neither marker
function automatic logic [15:0] noise_pixel();
    logic [4:0] r;
    logic [5:0] g;
    logic [4:0] b;
    logic [1:0] kind;
    kind = 2'(random_bits(2));
    case (kind)
        2'd0: begin  // green above the match limit
            r = 5'(random_bits(5));
            b = 5'(random_bits(5));
            g = 6'(32 + random_bits(5));
        end
        2'd1: begin  // grey, red equals blue
            r = 5'(random_bits(5));
            b = r;
            g = {r, 1'b0};
        end
        2'd2: begin  // red and blue both too high
            r = 5'(13 + random_bits(4));
            b = 5'(13 + random_bits(4));
            g = 6'(random_bits(6));
        end
        default: begin
            r = '0;
            b = '0;
            g = '0;
        end
    endcase
    return {r, g, b};
endfunction

function automatic logic inside_rect(int x, int y, rect_t r);
    return r.on && x >= r.x0 && x <= r.x1 && y >= r.y0 && y <= r.y1;
endfunction

function automatic logic [15:0] pixel_colour(int x, int y, rect_t red, rect_t blue, logic noise);
    if (inside_rect(x, y, red)) return 16'hf800;
    if (inside_rect(x, y, blue)) return 16'h001f;
    if (noise) return noise_pixel();
    return 16'h0000;
endfunction

task automatic send_byte(logic [7:0] b);
    cam_data = b;
    cam_pclk = 1'b0;
    step(4);
    cam_pclk = 1'b1;  // byte taken on this edge
    step(4);
endtask

// ends with vsync high, which closes the frame
task automatic send_frame(rect_t red, rect_t blue, logic noise);
    logic [15:0] px;
    int          x;
    int          y;
    cam_vsync = 1'b0;
    step(16);
    for (y = 0; y < FRAME_ROWS; y++) begin
        cam_href = 1'b1;
        for (x = 0; x < FRAME_COLS; x++) begin
            px = pixel_colour(x, y, red, blue, noise);
            send_byte(px[15:8]);
            send_byte(px[7:0]);
        end
        cam_href = 1'b0;
        cam_pclk = 1'b0;
        step(8);  // line gap
    end
    cam_vsync = 1'b1;
endtask

// File: dv/camera_tracker_tb.sv
`timescale 1ns/1ps

module camera_tracker_tb;
    import tracker_pkg::*;

    localparam int FRAME_COLS = 32;
    localparam int FRAME_ROWS = 16;
    localparam int RESULT_TIMEOUT = 2000;  // cycles from vsync to coords_valid

    logic       clk_in;
    logic       rst_in;
    logic [7:0] cam_data;
    logic       cam_pclk;
    logic       cam_vsync;
    logic       cam_href;
    logic       use_origin_head;
    logic       use_origin_hand;
    coord_t     head_x;
    coord_t     head_y;
    coord_t     hand_x;
    coord_t     hand_y;
    logic       head_found;
    logic       hand_found;
    logic       coords_valid;
    logic       origin_locked;

    int     errors = 0;
    int     results = 0;
    int     delivered = 0;  // frames that produced a result
    int     org_x = 0;
    int     org_y = 0;
    logic   idle_phase = 1'b0;  // no frame sent yet
    coord_t exp_head_x = '0;
    coord_t exp_head_y = '0;
    coord_t exp_hand_x = '0;
    coord_t exp_hand_y = '0;
    logic   exp_head_found = 1'b0;
    logic   exp_hand_found = 1'b0;
    logic   exp_locked = 1'b0;

    `include "camera_frames.svh"

    initial begin
        clk_in = 1'b0;
        forever #2 clk_in = ~clk_in;
    end

    camera_tracker_top u_dut (
        .clk_in          (clk_in),
        .rst_in          (rst_in),
        .cam_data        (cam_data),
        .cam_pclk        (cam_pclk),
        .cam_vsync       (cam_vsync),
        .cam_href        (cam_href),
        .use_origin_head (use_origin_head),
        .use_origin_hand (use_origin_hand),
        .head_x          (head_x),
        .head_y          (head_y),
        .hand_x          (hand_x),
        .hand_y          (hand_y),
        .head_found      (head_found),
        .hand_found      (hand_found),
        .coords_valid    (coords_valid),
        .origin_locked   (origin_locked)
    );

    task automatic step(int n);
        repeat (n) @(posedge clk_in);
        #1;
    endtask

    task automatic report_mismatch(string name, int got, int expected);
        errors++;
        $display("mismatch at %0t: %s = %0d, expected %0d", $time, name, got, expected);
    endtask

    function automatic int mean_floor(int lo, int hi);
        int sum;
        sum = 0;
        for (int v = lo; v <= hi; v++) sum += v;
        return sum / (hi - lo + 1);  // all coordinates non-negative
    endfunction

    function automatic int game_coord(int c, int o, logic rel);
        int v;
        v = rel ? o - c + GAME_OFFSET : c + GAME_OFFSET;
        return ((v % 4096) + 4096) % 4096;
    endfunction

    // expected outputs after this frame's result
    task automatic expect_frame(rect_t red, rect_t blue);
        int   cx;
        int   cy;
        logic locked_before;
        locked_before = exp_locked;
        exp_head_found = red.on;
        exp_hand_found = blue.on;
        if (red.on) begin
            cx = mean_floor(red.x0, red.x1);
            cy = mean_floor(red.y0, red.y1);
            exp_head_x = coord_t'(game_coord(cx, org_x, use_origin_head && locked_before));
            exp_head_y = coord_t'(game_coord(cy, org_y, use_origin_head && locked_before));
            if (!locked_before && delivered >= ORIGIN_FRAME - 1) begin  // origin capture
                org_x = cx;
                org_y = cy;
                exp_locked = 1'b1;
            end
        end
        if (blue.on) begin
            cx = mean_floor(blue.x0, blue.x1);
            cy = mean_floor(blue.y0, blue.y1);
            exp_hand_x = coord_t'(game_coord(cx, org_x, use_origin_hand && locked_before));
            exp_hand_y = coord_t'(game_coord(cy, org_y, use_origin_hand && locked_before));
        end
        delivered++;
    endtask

    task automatic wait_result();
        int cycles;
        cycles = 0;
        while (coords_valid !== 1'b1 && cycles < RESULT_TIMEOUT) begin
            step(1);
            cycles++;
        end
        if (coords_valid === 1'b1) begin
            results++;
        end else begin
            errors++;
            $display("timeout at %0t: no coords_valid within %0d cycles", $time, RESULT_TIMEOUT);
        end
        step(2);
    endtask

    task automatic run_frame(rect_t red, rect_t blue, logic noise);
        expect_frame(red, blue);
        send_frame(red, blue, noise);
        wait_result();
    endtask

    assert property (@(posedge clk_in) idle_phase |-> !coords_valid && !origin_locked
            && head_x == '0 && head_y == '0 && hand_x == '0 && hand_y == '0
            && !head_found && !hand_found)
        else begin
            errors++;
            $display("outputs left their reset values before the first frame at %0t", $time);
        end

    assert property (@(posedge clk_in) disable iff (rst_in)
        coords_valid |-> head_x == exp_head_x)
        else report_mismatch("head_x", int'($sampled(head_x)), int'($sampled(exp_head_x)));
    assert property (@(posedge clk_in) disable iff (rst_in)
        coords_valid |-> head_y == exp_head_y)
        else report_mismatch("head_y", int'($sampled(head_y)), int'($sampled(exp_head_y)));
    assert property (@(posedge clk_in) disable iff (rst_in)
        coords_valid |-> hand_x == exp_hand_x)
        else report_mismatch("hand_x", int'($sampled(hand_x)), int'($sampled(exp_hand_x)));
    assert property (@(posedge clk_in) disable iff (rst_in)
        coords_valid |-> hand_y == exp_hand_y)
        else report_mismatch("hand_y", int'($sampled(hand_y)), int'($sampled(exp_hand_y)));
    assert property (@(posedge clk_in) disable iff (rst_in)
        coords_valid |-> head_found == exp_head_found)
        else report_mismatch("head_found", int'($sampled(head_found)),
                             int'($sampled(exp_head_found)));
    assert property (@(posedge clk_in) disable iff (rst_in)
        coords_valid |-> hand_found == exp_hand_found)
        else report_mismatch("hand_found", int'($sampled(hand_found)),
                             int'($sampled(exp_hand_found)));
    assert property (@(posedge clk_in) disable iff (rst_in)
        coords_valid |-> origin_locked == exp_locked)
        else report_mismatch("origin_locked", int'($sampled(origin_locked)),
                             int'($sampled(exp_locked)));

    initial begin
        rst_in = 1'b1;
        cam_data = '0;
        cam_pclk = 1'b0;
        cam_vsync = 1'b0;
        cam_href = 1'b0;
        use_origin_head = 1'b0;
        use_origin_hand = 1'b0;
        step(1);
        idle_phase = 1'b1;  // outputs are reset from here on
        step(2);
        rst_in = 1'b0;
        step(10);
        idle_phase = 1'b0;

        run_frame(make_rect(4, 2, 9, 6), '0, 1'b0);  // head only
        run_frame(make_rect(4, 2, 9, 6), make_rect(20, 8, 27, 13), 1'b0);
        run_frame(make_rect(10, 3, 15, 7), '0, 1'b0);  // hand outputs hold
        run_frame(make_rect(10, 3, 15, 7), make_rect(18, 5, 25, 12), 1'b1);  // origin frame

        use_origin_head = 1'b1;
        use_origin_hand = 1'b1;
        run_frame(make_rect(14, 6, 19, 9), make_rect(2, 1, 7, 4), 1'b1);  // head past origin
        use_origin_hand = 1'b0;
        run_frame(make_rect(6, 1, 9, 3), make_rect(20, 9, 29, 14), 1'b1);
        use_origin_head = 1'b0;
        use_origin_hand = 1'b1;
        run_frame(make_rect(0, 0, 3, 1), make_rect(28, 12, 31, 15), 1'b1);  // frame corners
        use_origin_hand = 1'b0;
        run_frame(make_rect(8, 4, 13, 9), '0, 1'b1);  // hand holds across a mode change

        $display("errors: %0d, results checked: %0d", errors, results);
        if (errors == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

// File: src/camera_tracker_top.sv
`timescale 1ns/1ps

module camera_tracker_top (
    input  logic                clk_in,
    input  logic                rst_in,
    input  logic [7:0]          cam_data,
    input  logic                cam_pclk,
    input  logic                cam_vsync,
    input  logic                cam_href,
    input  logic                use_origin_head,
    input  logic                use_origin_hand,
    output tracker_pkg::coord_t head_x,
    output tracker_pkg::coord_t head_y,
    output tracker_pkg::coord_t hand_x,
    output tracker_pkg::coord_t hand_y,
    output logic                head_found,
    output logic                hand_found,
    output logic                coords_valid,
    output logic                origin_locked
);

    pixel_if    pix_bus ();
    centroid_if cen_bus ();

    pixel_decoder u_decoder (
        .clk_in    (clk_in),
        .rst_in    (rst_in),
        .cam_data  (cam_data),
        .cam_pclk  (cam_pclk),
        .cam_vsync (cam_vsync),
        .cam_href  (cam_href),
        .pix       (pix_bus.source)
    );

    centroid_accumulator u_accumulator (
        .clk_in (clk_in),
        .rst_in (rst_in),
        .pix    (pix_bus.sink),
        .cen    (cen_bus.producer)
    );

    origin_calibrator u_calibrator (
        .clk_in          (clk_in),
        .rst_in          (rst_in),
        .use_origin_head (use_origin_head),
        .use_origin_hand (use_origin_hand),
        .cen             (cen_bus.consumer),
        .head_x          (head_x),
        .head_y          (head_y),
        .hand_x          (hand_x),
        .hand_y          (hand_y),
        .head_found      (head_found),
        .hand_found      (hand_found),
        .coords_valid    (coords_valid),
        .origin_locked   (origin_locked)
    );

endmodule

// File: src/centroid_accumulator.sv
`timescale 1ns/1ps

module centroid_accumulator (
    input  logic         clk_in,
    input  logic         rst_in,
    pixel_if.sink        pix,
    centroid_if.producer cen
);
    import tracker_pkg::*;

    acc_state_t state;
    sum_t       live_hx;  // head sums
    sum_t       live_hy;
    count_t     live_hc;
    sum_t       live_bx;  // hand sums
    sum_t       live_by;
    count_t     live_bc;
    sum_t       hold_hx;
    sum_t       hold_hy;
    count_t     hold_hc;
    sum_t       hold_bx;
    sum_t       hold_by;
    count_t     hold_bc;
    logic [1:0] div_idx;  // head x, head y, hand x, hand y
    logic       div_busy;
    logic       div_start;
    logic       div_done;
    sum_t       div_dividend;
    count_t     div_divisor;
    coord_t     div_quotient;

    // frame_end and pix_valid never share a cycle
    always_ff @(posedge clk_in) begin
        if (rst_in || pix.frame_end) begin
            live_hx <= '0;
            live_hy <= '0;
            live_hc <= '0;
            live_bx <= '0;
            live_by <= '0;
            live_bc <= '0;
        end else if (pix.pix_valid) begin
            if (pix.is_head) begin
                live_hx <= live_hx + pix.x;
                live_hy <= live_hy + pix.y;
                live_hc <= live_hc + 1'b1;
            end
            if (pix.is_hand) begin
                live_bx <= live_bx + pix.x;
                live_by <= live_by + pix.y;
                live_bc <= live_bc + 1'b1;
            end
        end
    end

    always_ff @(posedge clk_in) begin
        if (pix.frame_end && state == IDLE) begin  // a busy stage drops the frame
            hold_hx <= live_hx;
            hold_hy <= live_hy;
            hold_hc <= live_hc;
            hold_bx <= live_bx;
            hold_by <= live_by;
            hold_bc <= live_bc;
        end
    end

    always_comb begin
        case (div_idx)
            2'd0: div_dividend = hold_hx;
            2'd1: div_dividend = hold_hy;
            2'd2: div_dividend = hold_bx;
            default: div_dividend = hold_by;
        endcase
    end

    assign div_divisor = div_idx[1] ? hold_bc : hold_hc;
    assign div_start = state == DIVIDE && !div_busy && div_divisor != '0;

    serial_divider u_divider (
        .clk_in   (clk_in),
        .rst_in   (rst_in),
        .start    (div_start),
        .dividend (div_dividend),
        .divisor  (div_divisor),
        .quotient (div_quotient),
        .done     (div_done)
    );

    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            state <= IDLE;
            div_idx <= '0;
            div_busy <= 1'b0;
            cen.req <= 1'b0;
            cen.head_found <= 1'b0;
            cen.hand_found <= 1'b0;
        end else begin
            case (state)
                IDLE: if (pix.frame_end) begin
                    state <= DIVIDE;
                    div_idx <= '0;
                    cen.head_found <= live_hc != '0;
                    cen.hand_found <= live_bc != '0;
                end
                DIVIDE: if (div_start) begin
                    div_busy <= 1'b1;
                end else if (!div_busy || div_done) begin  // zero count skips
                    div_busy <= 1'b0;
                    div_idx <= div_idx + 1'b1;
                    if (div_idx == 2'd3) begin
                        state <= REQUEST;
                        cen.req <= 1'b1;
                    end
                end
                REQUEST: if (cen.ack) begin
                    cen.req <= 1'b0;
                    state <= RELEASE;
                end
                RELEASE: if (!cen.ack) state <= IDLE;
                default: state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk_in) begin
        if (state == DIVIDE && div_done) begin
            case (div_idx)
                2'd0: cen.head_x <= div_quotient;
                2'd1: cen.head_y <= div_quotient;
                2'd2: cen.hand_x <= div_quotient;
                default: cen.hand_y <= div_quotient;
            endcase
        end
    end

    // req holds until the calibrator answers
    assert property (@(posedge clk_in) disable iff (rst_in) cen.req && !cen.ack |=> cen.req);

endmodule

// File: src/origin_calibrator.sv
`timescale 1ns/1ps

module origin_calibrator (
    input  logic                clk_in,
    input  logic                rst_in,
    input  logic                use_origin_head,
    input  logic                use_origin_hand,
    centroid_if.consumer        cen,
    output tracker_pkg::coord_t head_x,
    output tracker_pkg::coord_t head_y,
    output tracker_pkg::coord_t hand_x,
    output tracker_pkg::coord_t hand_y,
    output logic                head_found,
    output logic                hand_found,
    output logic                coords_valid,
    output logic                origin_locked
);
    import tracker_pkg::*;

    logic [ORIGIN_CNT_W-1:0] frame_cnt;  // delivered frames, saturates
    coord_t                  origin_x;
    coord_t                  origin_y;
    logic                    take;
    logic                    lock_now;
    logic                    rel_head;
    logic                    rel_hand;

    function automatic coord_t game_value(coord_t c, coord_t o, logic rel);
        if (rel) return coord_t'(o - c + GAME_OFFSET);  // wraps mod 4096
        return coord_t'(c + GAME_OFFSET);
    endfunction

    assign take = cen.req && !cen.ack;  // new result from the accumulator
    assign lock_now = take && !origin_locked && cen.head_found
                      && frame_cnt == ORIGIN_CNT_W'(ORIGIN_FRAME - 1);
    assign rel_head = use_origin_head && origin_locked;
    assign rel_hand = use_origin_hand && origin_locked;

    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            cen.ack <= 1'b0;
            coords_valid <= 1'b0;
            origin_locked <= 1'b0;
            frame_cnt <= '0;
            head_x <= '0;
            head_y <= '0;
            hand_x <= '0;
            hand_y <= '0;
            head_found <= 1'b0;
            hand_found <= 1'b0;
        end else begin
            cen.ack <= cen.req;
            coords_valid <= take;
            if (take) begin
                if (frame_cnt != ORIGIN_CNT_W'(ORIGIN_FRAME - 1)) frame_cnt <= frame_cnt + 1'b1;
                if (lock_now) origin_locked <= 1'b1;
                head_found <= cen.head_found;
                hand_found <= cen.hand_found;
                if (cen.head_found) begin
                    head_x <= game_value(cen.head_x, origin_x, rel_head);
                    head_y <= game_value(cen.head_y, origin_y, rel_head);
                end
                if (cen.hand_found) begin
                    hand_x <= game_value(cen.hand_x, origin_x, rel_hand);
                    hand_y <= game_value(cen.hand_y, origin_y, rel_hand);
                end
            end
        end
    end

    always_ff @(posedge clk_in) begin
        if (lock_now) begin  // head position at rest
            origin_x <= cen.head_x;
            origin_y <= cen.head_y;
        end
    end

    assert property (@(posedge clk_in) disable iff (rst_in) $rose(cen.ack) |-> $past(cen.req));

endmodule

// File: src/pixel_decoder.sv
`timescale 1ns/1ps

module pixel_decoder (
    input  logic       clk_in,
    input  logic       rst_in,
    input  logic [7:0] cam_data,
    input  logic       cam_pclk,
    input  logic       cam_vsync,
    input  logic       cam_href,
    pixel_if.source    pix
);
    import tracker_pkg::*;

    logic [10:0] cam_meta;  // first sync stage
    logic [10:0] cam_sync;  // second sync stage
    logic [7:0]  data_s;
    logic        pclk_s;
    logic        href_s;
    logic        vsync_s;
    logic        pclk_d;
    logic        href_d;
    logic        vsync_d;
    logic        pclk_rise;
    logic        href_fall;
    logic        vsync_rise;
    logic        take_byte;
    logic        second_byte;  // next byte completes a pixel
    logic [7:0]  hi_byte;
    rgb565_t     pixel;
    logic        match_head;
    logic        match_hand;
    coord_t      x_cnt;
    coord_t      y_cnt;

    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            cam_meta <= '0;
            cam_sync <= '0;
            pclk_d <= 1'b0;
            href_d <= 1'b0;
            vsync_d <= 1'b0;
        end else begin
            cam_meta <= {cam_data, cam_pclk, cam_href, cam_vsync};
            cam_sync <= cam_meta;
            pclk_d <= pclk_s;
            href_d <= href_s;
            vsync_d <= vsync_s;
        end
    end

    assign data_s = cam_sync[10:3];
    assign pclk_s = cam_sync[2];
    assign href_s = cam_sync[1];
    assign vsync_s = cam_sync[0];

    assign pclk_rise = pclk_s && !pclk_d;
    assign href_fall = href_d && !href_s;
    assign vsync_rise = vsync_s && !vsync_d;
    assign take_byte = pclk_rise && href_s;

    // high byte arrives first
    assign pixel = {hi_byte, data_s};
    assign match_head = pixel[15:11] >= RED_MIN && pixel[4:0] <= OTHER_MAX
                        && pixel[10:5] <= GREEN_MAX;
    assign match_hand = pixel[4:0] >= BLUE_MIN && pixel[15:11] <= OTHER_MAX
                        && pixel[10:5] <= GREEN_MAX;

    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            second_byte <= 1'b0;
            x_cnt <= '0;
            y_cnt <= '0;
            pix.pix_valid <= 1'b0;
            pix.frame_end <= 1'b0;
        end else begin
            pix.pix_valid <= take_byte && second_byte;
            pix.frame_end <= vsync_rise;
            if (take_byte) begin
                second_byte <= !second_byte;
                if (second_byte) x_cnt <= x_cnt + 1'b1;
            end
            if (href_fall) begin  // line done
                second_byte <= 1'b0;
                x_cnt <= '0;
                y_cnt <= y_cnt + 1'b1;
            end
            if (vsync_rise) y_cnt <= '0;
        end
    end

    always_ff @(posedge clk_in) begin
        if (take_byte && !second_byte) hi_byte <= data_s;
        if (take_byte && second_byte) begin
            pix.x <= x_cnt;
            pix.y <= y_cnt;
            pix.is_head <= match_head;
            pix.is_hand <= match_hand;
        end
    end

    // a pixel can only carry one marker colour
    assert property (@(posedge clk_in) disable iff (rst_in)
        pix.pix_valid |-> !(pix.is_head && pix.is_hand));

endmodule

// File: src/serial_divider.sv
`timescale 1ns/1ps

module serial_divider (
    input  logic                clk_in,
    input  logic                rst_in,
    input  logic                start,
    input  tracker_pkg::sum_t   dividend,
    input  tracker_pkg::count_t divisor,
    output tracker_pkg::coord_t quotient,
    output logic                done
);
    import tracker_pkg::*;

    sum_t                 quo;  // dividend shifts out, quotient bits shift in
    count_t               rem;
    count_t               dvs;
    logic [COUNT_W:0]     trial;
    logic [DIV_CNT_W-1:0] bits_left;
    logic                 busy;

    assign trial = {rem, quo[SUM_W-1]};
    assign quotient = quo[COORD_W-1:0];  // mean is below frame width

    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            busy <= 1'b0;
            bits_left <= '0;
            done <= 1'b0;
        end else begin
            done <= 1'b0;
            if (start) begin
                busy <= 1'b1;
                bits_left <= DIV_CNT_W'(SUM_W);
            end else if (busy) begin
                bits_left <= bits_left - 1'b1;
                if (bits_left == 1) begin  // last quotient bit
                    busy <= 1'b0;
                    done <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk_in) begin
        if (start) begin
            quo <= dividend;
            rem <= '0;
            dvs <= divisor;
        end else if (busy) begin
            if (trial >= {1'b0, dvs}) begin  // restore skipped
                rem <= count_t'(trial - {1'b0, dvs});
                quo <= {quo[SUM_W-2:0], 1'b1};
            end else begin
                rem <= trial[COUNT_W-1:0];
                quo <= {quo[SUM_W-2:0], 1'b0};
            end
        end
    end

    assert property (@(posedge clk_in) disable iff (rst_in) start |-> divisor != '0);

endmodule

// File: src/tracker_ifs.sv
`timescale 1ns/1ps

interface pixel_if;
    import tracker_pkg::*;

    logic   pix_valid;
    coord_t x;
    coord_t y;
    logic   is_head;
    logic   is_hand;
    logic   frame_end;

    modport source (output pix_valid, x, y, is_head, is_hand, frame_end);
    modport sink (input pix_valid, x, y, is_head, is_hand, frame_end);
endinterface

interface centroid_if;
    import tracker_pkg::*;

    logic   req;
    logic   ack;
    coord_t head_x;
    coord_t head_y;
    coord_t hand_x;
    coord_t hand_y;
    logic   head_found;
    logic   hand_found;

    modport producer (output req, head_x, head_y, hand_x, hand_y, head_found, hand_found,
                      input ack);
    modport consumer (input req, head_x, head_y, hand_x, hand_y, head_found, hand_found,
                      output ack);
endinterface

// File: src/tracker_pkg.sv
package tracker_pkg;

    // frame geometry, only used to size the types below
    localparam int FRAME_W = 640;
    localparam int FRAME_H = 480;

    localparam int COORD_W = 12;  // holds game values after the offset
    localparam int COUNT_W = $clog2(FRAME_W * FRAME_H + 1);  // 19 bits
    localparam int SUM_W = COUNT_W + $clog2(FRAME_W);  // 29 bits

    typedef logic [COORD_W-1:0] coord_t;
    typedef logic [COUNT_W-1:0] count_t;
    typedef logic [SUM_W-1:0] sum_t;
    typedef logic [15:0] rgb565_t;

    // colour match thresholds on the 5/6/5 components
    localparam int RED_MIN = 20;
    localparam int BLUE_MIN = 20;
    localparam int OTHER_MAX = 12;  // other 5-bit component
    localparam int GREEN_MAX = 24;

    // calibration
    localparam int GAME_OFFSET = 1800;
    localparam int ORIGIN_FRAME = 4;  // delivered frame that sets the origin
    localparam int ORIGIN_CNT_W = $clog2(ORIGIN_FRAME + 1);

    localparam int DIV_CNT_W = $clog2(SUM_W + 1);  // divider step counter

    typedef enum logic [1:0] {
        IDLE,
        DIVIDE,
        REQUEST,
        RELEASE
    } acc_state_t;

endpackage

// File: verilog.f
+incdir+dv
src/tracker_pkg.sv
src/tracker_ifs.sv
src/pixel_decoder.sv
src/serial_divider.sv
src/centroid_accumulator.sv
src/origin_calibrator.sv
src/camera_tracker_top.sv
dv/camera_tracker_tb.sv
